// File: Makefile
SIM        := verilator
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only -Wall --timing
TOP        := fp_add_unit_tb
RTL_TOP    := fp_add_unit
FILELIST   := project.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the log decides pass or fail
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: logic/fp_add_core.sv
`timescale 1ns/1ns
`include "fp_defines.svh"

module fp_add_core (
  input  logic                  clk,
  input  logic                  rst,
  input  op_pkg::operand_pair_t pair,
  input  logic                  pair_stb,
  output logic                  pair_ack,
  output fp_pkg::fp64_u         output_z,
  output logic                  output_z_stb,
  input  logic                  output_z_ack
);

  typedef enum logic [3:0] {
    st_idle      = 4'd0,
    st_special   = 4'd1,
    st_align     = 4'd2,
    st_add       = 4'd3,
    st_carry     = 4'd4,
    st_norm_up   = 4'd5,
    st_norm_down = 4'd6,
    st_round     = 4'd7,
    st_pack      = 4'd8,
    st_put       = 4'd9
  } state_t;

  // smallest normal exponent and largest finite exponent
  localparam fp_pkg::uexp_t e_min = fp_pkg::uexp_t'(1 - `FP_BIAS);
  localparam fp_pkg::uexp_t e_max = fp_pkg::uexp_t'(`FP_BIAS);
  localparam logic [`FP_EXP_W-1:0] exp_bias = `FP_EXP_W'(`FP_BIAS);

  state_t state;

  // operand words as taken from the collector
  fp_pkg::fp64_u a_w;
  fp_pkg::fp64_u b_w;

  // decoded views of those words
  fp_pkg::fp_operand_t a_u;
  fp_pkg::fp_operand_t b_u;

  // working copies that align shifts in place
  fp_pkg::fp_operand_t a_op;
  fp_pkg::fp_operand_t b_op;

  // one extra bit on top for the carry out of the add
  logic [fp_pkg::mant_w:0] sum;
  logic [`FP_FRAC_W:0]     z_m;
  fp_pkg::uexp_t           z_e;
  logic                    z_s;
  logic                    guard;
  logic                    round_bit;
  logic                    sticky;

  fp_pkg::fp64_u z;
  fp_pkg::fp64_u packed_z;
  logic          pair_ack_q;
  logic          out_stb;

  // signed infinity word
  function automatic fp_pkg::fp64_u inf_word(input logic sign);
    fp_pkg::fp64_u w;
    w.f.sign = sign;
    w.f.exp  = '1;
    w.f.frac = '0;
    return w;
  endfunction

  fp_unpack u_unpack_a (
    .word (a_w),
    .opnd (a_u)
  );

  fp_unpack u_unpack_b (
    .word (b_w),
    .opnd (b_u)
  );

  // result word assembled from the rounded mantissa
  always_comb begin
    packed_z.f.sign = z_s;
    packed_z.f.exp  = z_e[`FP_EXP_W-1:0] + exp_bias;
    packed_z.f.frac = z_m[`FP_FRAC_W-1:0];
    // no hidden bit at the bottom exponent means a denormal
    if (z_e == e_min && !z_m[`FP_FRAC_W]) begin
      packed_z.f.exp = '0;
    end
    // past the largest finite exponent
    if (z_e > e_max) begin
      packed_z = inf_word(z_s);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      pair_ack_q <= 1'b0;
      out_stb    <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          pair_ack_q <= 1'b1;
          if (pair_ack_q && pair_stb) begin
            a_w        <= pair.a;
            b_w        <= pair.b;
            pair_ack_q <= 1'b0;
            state      <= st_special;
          end
        end

        st_special: begin
          // default path loads the decoded operands for alignment
          a_op  <= a_u;
          b_op  <= b_u;
          state <= st_put;
          out_stb <= 1'b1;
          if (a_u.is_nan || b_u.is_nan) begin
            z <= `FP_NAN_WORD;
          end else if (a_u.is_inf) begin
            // opposite infinities have no defined sum
            if (b_u.is_inf && (a_u.sign != b_u.sign)) begin
              z <= `FP_NAN_WORD;
            end else begin
              z <= inf_word(a_u.sign);
            end
          end else if (b_u.is_inf) begin
            z <= inf_word(b_u.sign);
          end else if (a_u.is_zero && b_u.is_zero) begin
            // only -0 + -0 keeps the sign
            z <= inf_word(a_u.sign & b_u.sign);
            z.f.exp <= '0;
          end else if (a_u.is_zero) begin
            z <= b_w;
          end else if (b_u.is_zero) begin
            z <= a_w;
          end else if ({a_w.f.exp, a_w.f.frac} == {b_w.f.exp, b_w.f.frac} &&
                       a_w.f.sign != b_w.f.sign) begin
            // x + (-x) is +0 under nearest-even
            z <= '0;
          end else begin
            out_stb <= 1'b0;
            state   <= st_align;
          end
        end

        st_align: begin
          // shift the smaller one right, folding lost bits into sticky
          if (a_op.exp > b_op.exp) begin
            b_op.exp  <= b_op.exp + 1'b1;
            b_op.mant <= {1'b0, b_op.mant[fp_pkg::mant_w-1:2], b_op.mant[1] | b_op.mant[0]};
          end else if (a_op.exp < b_op.exp) begin
            a_op.exp  <= a_op.exp + 1'b1;
            a_op.mant <= {1'b0, a_op.mant[fp_pkg::mant_w-1:2], a_op.mant[1] | a_op.mant[0]};
          end else begin
            state <= st_add;
          end
        end

        st_add: begin
          z_e <= a_op.exp;
          if (a_op.sign == b_op.sign) begin
            sum <= {1'b0, a_op.mant} + {1'b0, b_op.mant};
            z_s <= a_op.sign;
          end else if (a_op.mant > b_op.mant) begin
            // magnitude subtract, larger operand gives the sign
            sum <= {1'b0, a_op.mant} - {1'b0, b_op.mant};
            z_s <= a_op.sign;
          end else begin
            sum <= {1'b0, b_op.mant} - {1'b0, a_op.mant};
            z_s <= b_op.sign;
          end
          state <= st_carry;
        end

        st_carry: begin
          // a carry out moves the point one place left
          if (sum[fp_pkg::mant_w]) begin
            z_m       <= sum[fp_pkg::mant_w:4];
            guard     <= sum[3];
            round_bit <= sum[2];
            sticky    <= sum[1] | sum[0];
            z_e       <= z_e + 1'b1;
          end else begin
            z_m       <= sum[fp_pkg::mant_w-1:3];
            guard     <= sum[2];
            round_bit <= sum[1];
            sticky    <= sum[0];
          end
          state <= st_norm_up;
        end

        st_norm_up: begin
          // one leading zero per cycle, stop at the denormal floor
          if (!z_m[`FP_FRAC_W] && z_e > e_min) begin
            z_e       <= z_e - 1'b1;
            z_m       <= {z_m[`FP_FRAC_W-1:0], guard};
            guard     <= round_bit;
            round_bit <= 1'b0;
          end else begin
            state <= st_norm_down;
          end
        end

        st_norm_down: begin
          // pull an exponent below the floor back up into denormal form
          if (z_e < e_min) begin
            z_e       <= z_e + 1'b1;
            z_m       <= {1'b0, z_m[`FP_FRAC_W:1]};
            guard     <= z_m[0];
            round_bit <= guard;
            sticky    <= sticky | round_bit;
          end else begin
            state <= st_round;
          end
        end

        st_round: begin
          // nearest-even: up when above half, or at half with odd lsb
          if (guard && (round_bit | sticky | z_m[0])) begin
            z_m <= z_m + 1'b1;
            // all-ones mantissa wraps to zero with the next exponent
            if (&z_m) begin
              z_e <= z_e + 1'b1;
            end
          end
          state <= st_pack;
        end

        st_pack: begin
          z       <= packed_z;
          out_stb <= 1'b1;
          state   <= st_put;
        end

        st_put: begin
          // hold the result until the receiver takes it
          if (out_stb && output_z_ack) begin
            out_stb <= 1'b0;
            state   <= st_idle;
          end
        end

        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  assign pair_ack     = pair_ack_q;
  assign output_z     = z;
  assign output_z_stb = out_stb;

  // result must not move under a stalled receiver
  assert property (@(posedge clk) disable iff (rst)
    output_z_stb && !output_z_ack |=> output_z_stb && $stable(output_z));

  assert property (@(posedge clk) disable iff (rst)
    state inside {st_idle, st_special, st_align, st_add, st_carry,
                  st_norm_up, st_norm_down, st_round, st_pack, st_put});

endmodule

// File: logic/fp_add_unit.sv
`timescale 1ns/1ns

module fp_add_unit (
  input  logic               clk,
  input  logic               rst,
  input  fp_pkg::fp64_u      input_a,
  input  logic               input_a_stb,
  output logic               input_a_ack,
  input  op_pkg::operand_b_t input_b,
  input  logic               input_b_stb,
  output logic               input_b_ack,
  output fp_pkg::fp64_u      output_z,
  output logic               output_z_stb,
  input  logic               output_z_ack
);

  // collector to core transfer
  op_pkg::operand_pair_t pair;
  logic                  pair_stb;
  logic                  pair_ack;

  // gathers a and b, applies the subtract flag
  fp_operand_collector u_collector (
    .clk         (clk),
    .rst         (rst),
    .input_a     (input_a),
    .input_a_stb (input_a_stb),
    .input_a_ack (input_a_ack),
    .input_b     (input_b),
    .input_b_stb (input_b_stb),
    .input_b_ack (input_b_ack),
    .pair        (pair),
    .pair_stb    (pair_stb),
    .pair_ack    (pair_ack)
  );

  // one add in flight at a time
  fp_add_core u_core (
    .clk          (clk),
    .rst          (rst),
    .pair         (pair),
    .pair_stb     (pair_stb),
    .pair_ack     (pair_ack),
    .output_z     (output_z),
    .output_z_stb (output_z_stb),
    .output_z_ack (output_z_ack)
  );

endmodule

// File: logic/fp_defines.svh
`ifndef FP_DEFINES_SVH
`define FP_DEFINES_SVH

// binary64 word layout
`define FP_WIDTH 64
`define FP_EXP_W 11
`define FP_FRAC_W 52

// exponent bias for binary64
`define FP_BIAS 1023

// every NaN result leaves the unit as this one word
// sign set, all-ones exponent, quiet bit set, rest zero
`define FP_NAN_WORD 64'hfff8_0000_0000_0000

`endif

// File: logic/fp_operand_collector.sv
`timescale 1ns/1ns

module fp_operand_collector (
  input  logic                  clk,
  input  logic                  rst,
  input  fp_pkg::fp64_u         input_a,
  input  logic                  input_a_stb,
  output logic                  input_a_ack,
  input  op_pkg::operand_b_t    input_b,
  input  logic                  input_b_stb,
  output logic                  input_b_ack,
  output op_pkg::operand_pair_t pair,
  output logic                  pair_stb,
  input  logic                  pair_ack
);

  // one slot per operand, each with its own full flag
  logic a_full;
  logic b_full;
  logic a_ack_q;
  logic b_ack_q;
  logic pair_stb_q;
  op_pkg::operand_pair_t pair_q;

  // handshake events of this cycle
  logic a_take;
  logic b_take;
  logic pair_done;

  // b with the subtract folded into its sign
  fp_pkg::fp64_u b_signed;

  assign a_take    = a_ack_q && input_a_stb;
  assign b_take    = b_ack_q && input_b_stb;
  assign pair_done = pair_stb_q && pair_ack;

  always_comb begin
    b_signed        = input_b.value;
    b_signed.f.sign = input_b.value.f.sign ^ input_b.sub;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      a_full     <= 1'b0;
      b_full     <= 1'b0;
      a_ack_q    <= 1'b0;
      b_ack_q    <= 1'b0;
      pair_stb_q <= 1'b0;
    end else begin
      // ack comes back one cycle after a slot is seen empty
      a_ack_q <= ~a_full;
      b_ack_q <= ~b_full;
      if (a_take) begin
        pair_q.a <= input_a;
        a_full   <= 1'b1;
        a_ack_q  <= 1'b0;
      end
      if (b_take) begin
        pair_q.b <= b_signed;
        b_full   <= 1'b1;
        b_ack_q  <= 1'b0;
      end
      // pair goes out the cycle after both slots fill
      // and stays until the core takes it
      if (pair_done) begin
        a_full     <= 1'b0;
        b_full     <= 1'b0;
        pair_stb_q <= 1'b0;
      end else if (a_full && b_full) begin
        pair_stb_q <= 1'b1;
      end
    end
  end

  assign input_a_ack = a_ack_q;
  assign input_b_ack = b_ack_q;
  assign pair        = pair_q;
  assign pair_stb    = pair_stb_q;

  // a full slot never invites another operand
  assert property (@(posedge clk) disable iff (rst) input_a_ack |-> !a_full);
  assert property (@(posedge clk) disable iff (rst) input_b_ack |-> !b_full);

endmodule

// File: logic/fp_pkg.sv
`include "fp_defines.svh"

package fp_pkg;

  // unbiased exponent needs two extra bits
  // covers -1023..1024 plus carry/overflow headroom
  localparam int uexp_w = `FP_EXP_W + 2;

  // hidden bit, fraction, then guard/round/sticky
  localparam int mant_w = `FP_FRAC_W + 4;

  typedef logic signed [uexp_w-1:0] uexp_t;
  typedef logic [mant_w-1:0] mant_t;

  // field view of a binary64 word, msb first
  typedef struct packed {
    logic                 sign;
    logic [`FP_EXP_W-1:0]  exp;
    logic [`FP_FRAC_W-1:0] frac;
  } fp64_fields_t;

  // same 64 bits seen either as a raw word or as fields
  typedef union packed {
    logic [`FP_WIDTH-1:0] raw;
    fp64_fields_t         f;
  } fp64_u;

  // decoded operand as the adder works on it
  // denormals carry exp -1022 and a cleared hidden bit
  typedef struct packed {
    logic  sign;
    uexp_t exp;
    mant_t mant;
    logic  is_nan;
    logic  is_inf;
    logic  is_zero;
  } fp_operand_t;

endpackage

// File: logic/fp_unpack.sv
`timescale 1ns/1ns
`include "fp_defines.svh"

module fp_unpack (
  input  fp_pkg::fp64_u       word,
  output fp_pkg::fp_operand_t opnd
);

  logic exp_zero;
  logic exp_ones;
  logic frac_zero;

  // class detection straight from the raw fields
  assign exp_zero  = (word.f.exp == '0);
  assign exp_ones  = (word.f.exp == '1);
  assign frac_zero = (word.f.frac == '0);

  always_comb begin
    opnd.sign = word.f.sign;

    // denormals share the exponent of the smallest normal
    if (exp_zero) begin
      opnd.exp = fp_pkg::uexp_t'(1 - `FP_BIAS);
    end else begin
      opnd.exp = fp_pkg::uexp_t'({2'b00, word.f.exp}) - fp_pkg::uexp_t'(`FP_BIAS);
    end

    // hidden bit only for normal numbers
    // grs positions start out clear
    opnd.mant = {~exp_zero, word.f.frac, 3'b000};

    // all-ones exponent splits into nan and inf on the fraction
    opnd.is_nan  = exp_ones & ~frac_zero;
    opnd.is_inf  = exp_ones & frac_zero;
    opnd.is_zero = exp_zero & frac_zero;
  end

endmodule

// File: logic/op_pkg.sv
package op_pkg;

  // b operand as it arrives from outside
  // sub asks the unit to compute a - b
  typedef struct packed {
    logic          sub;
    fp_pkg::fp64_u value;
  } operand_b_t;

  // both operands handed to the core in one transfer
  // b already carries the flipped sign for a subtract
  typedef struct packed {
    fp_pkg::fp64_u a;
    fp_pkg::fp64_u b;
  } operand_pair_t;

endpackage

// File: project.f
+incdir+logic
logic/fp_pkg.sv
logic/op_pkg.sv
logic/fp_unpack.sv
logic/fp_operand_collector.sv
logic/fp_add_core.sv
logic/fp_add_unit.sv
test/tb_clock.sv
test/fp_add_unit_tb.sv

// File: test/fp_add_trace.txt
# op a b z : op 0 is a + b, op 1 is a - b
# all values are binary64 words in hex, z rounded to nearest-even
0 3ff0000000000000 3ff0000000000000 4000000000000000
0 3ff0000000000000 4000000000000000 4008000000000000
0 3ff8000000000000 3fd0000000000000 3ffc000000000000
1 4008000000000000 3ff0000000000000 4000000000000000
1 3ff0000000000000 4008000000000000 c000000000000000
0 3fb999999999999a 3fc999999999999a 3fd3333333333334
0 3ff0000000000000 3ca0000000000000 3ff0000000000000
0 3ff0000000000001 3ca0000000000000 3ff0000000000002
0 3ff0000000000000 3ca0000000000001 3ff0000000000001
1 3ff0000000000000 3ff0000000000000 0000000000000000
0 c004000000000000 4004000000000000 0000000000000000
1 3ff0000000000000 3fefffffffffffff 3ca0000000000000
1 3ff0000000000001 3ff0000000000000 3cb0000000000000
0 0000000000000001 0000000000000001 0000000000000002
0 000fffffffffffff 0000000000000001 0010000000000000
1 0010000000000000 0000000000000001 000fffffffffffff
1 0010000000000001 0010000000000000 0000000000000001
0 7ff8000000000000 3ff0000000000000 fff8000000000000
1 7ff0000000000000 7ff0000000000000 fff8000000000000
0 7ff0000000000000 c000000000000000 7ff0000000000000
1 0000000000000000 4008000000000000 c008000000000000
0 8000000000000000 8000000000000000 8000000000000000
0 7fefffffffffffff 7fefffffffffffff 7ff0000000000000
1 ffefffffffffffff 7fefffffffffffff fff0000000000000

// File: test/fp_add_unit_tb.sv
`timescale 1ns/1ns

module fp_add_unit_tb;

  localparam int max_ops       = 64;
  localparam int cycles_per_op = 200;
  localparam int drive_delay   = 2;
  localparam logic [31:0] seed = 32'hc6d7_1644;

  logic clk;
  logic rst;

  fp_pkg::fp64_u      input_a;
  logic               input_a_stb;
  logic               input_a_ack;
  op_pkg::operand_b_t input_b;
  logic               input_b_stb;
  logic               input_b_ack;
  fp_pkg::fp64_u      output_z;
  logic               output_z_stb;
  logic               output_z_ack;

  // trace contents, one entry per operation
  logic        op_sub [max_ops];
  logic [63:0] op_a   [max_ops];
  logic [63:0] op_b   [max_ops];
  logic [63:0] exp_z  [max_ops];
  int          n_ops = 0;
  logic        trace_loaded = 1'b0;
  int          error_count = 0;
  logic [31:0] rnd_state = seed;

  tb_clock clock_gen (
    .clk (clk),
    .rst (rst)
  );

  fp_add_unit dut (
    .clk          (clk),
    .rst          (rst),
    .input_a      (input_a),
    .input_a_stb  (input_a_stb),
    .input_a_ack  (input_a_ack),
    .input_b      (input_b),
    .input_b_stb  (input_b_stb),
    .input_b_ack  (input_b_ack),
    .output_z     (output_z),
    .output_z_stb (output_z_stb),
    .output_z_ack (output_z_ack)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // driver draws at edge+2, receiver at negedges, so calls never share a time step
  function automatic int random_below(input int n);
    rnd_state = xorshift(rnd_state);
    return int'(rnd_state % n);
  endfunction

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      error_count++;
      $display("Error %0t %s got %h expected %h", $time, name, got, expected);
      abort_run();
    end
  endtask

  // lines starting with # are comments, the rest hold op a b z in hex
  task automatic load_trace();
    int    fd;
    int    n;
    int    op;
    string line;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] z;
    fd = $fopen("test/fp_add_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file test/fp_add_trace.txt");
      abort_run();
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h", op, a, b, z);
          if (n == 4 && n_ops < max_ops) begin
            op_sub[n_ops] = (op != 0);
            op_a[n_ops]   = a;
            op_b[n_ops]   = b;
            exp_z[n_ops]  = z;
            n_ops++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // hold stb and data until an edge that closes a cycle with ack high
  task automatic send_a(input logic [63:0] value, input int gap);
    repeat (gap) begin
      @(posedge clk);
      #drive_delay;
    end
    input_a.raw = value;
    input_a_stb = 1'b1;
    @(negedge clk);
    while (!input_a_ack) @(negedge clk);
    @(posedge clk);
    #drive_delay;
    input_a_stb = 1'b0;
  endtask

  task automatic send_b(input logic sub, input logic [63:0] value, input int gap);
    repeat (gap) begin
      @(posedge clk);
      #drive_delay;
    end
    input_b.sub       = sub;
    input_b.value.raw = value;
    input_b_stb       = 1'b1;
    @(negedge clk);
    while (!input_b_ack) @(negedge clk);
    @(posedge clk);
    #drive_delay;
    input_b_stb = 1'b0;
  endtask

  task automatic drive_operands();
    int gap_a;
    int gap_b;
    for (int i = 0; i < n_ops; i++) begin
      // 0..3 idle cycles before each operand
      gap_a = random_below(4);
      gap_b = random_below(4);
      fork
        send_a(op_a[i], gap_a);
        send_b(op_sub[i], op_b[i], gap_b);
      join
    end
  endtask

  task automatic collect_results();
    int hold;
    for (int i = 0; i < n_ops; i++) begin
      @(negedge clk);
      while (!output_z_stb) @(negedge clk);
      // back-pressure of 0..4 cycles
      hold = random_below(5);
      repeat (hold) @(negedge clk);
      @(posedge clk);
      #drive_delay;
      output_z_ack = 1'b1;
      // value taken on the coming edge
      @(negedge clk);
      check_value("output_z_stb", {63'b0, output_z_stb}, 64'd1);
      check_value("output_z", output_z.raw, exp_z[i]);
      @(posedge clk);
      #drive_delay;
      output_z_ack = 1'b0;
    end
  endtask

  initial begin
    input_a      = '0;
    input_a_stb  = 1'b0;
    input_b      = '0;
    input_b_stb  = 1'b0;
    output_z_ack = 1'b0;
    load_trace();
    if (n_ops == 0) begin
      $display("the trace file holds no operations");
      abort_run();
    end
    trace_loaded = 1'b1;
    wait (rst === 1'b0);
    fork
      drive_operands();
      collect_results();
    join
    // a duplicated result would show up here
    repeat (10) begin
      @(negedge clk);
      if (output_z_stb) begin
        $display("an extra result was offered after the last trace line");
        abort_run();
      end
    end
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      abort_run();
    end
  end

  // 200 cycles per trace line, one line of slack for reset
  initial begin
    wait (trace_loaded);
    repeat ((n_ops + 1) * cycles_per_op) @(posedge clk);
    $display("timeout, the run did not finish within %0d clock cycles",
             (n_ops + 1) * cycles_per_op);
    abort_run();
  end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int half_period  = 20,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // reset spans the first edges, released just after an edge like other inputs
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #2 rst = 1'b0;
  end

endmodule
